// ==== beam_timing.sv ====
`default_nettype none

module beam_timing #(
	parameter int H_TOTAL        = 384,
	parameter int H_ACTIVE_START = 14,
	parameter int H_ACTIVE_END   = 283,
	parameter int H_SYNC_START   = 300,
	parameter int H_SYNC_LEN     = 32,
	parameter int V_TOTAL        = 264,
	parameter int V_ACTIVE_START = 16,
	parameter int V_ACTIVE_END   = 240,
	parameter int V_SYNC_START   = 248,
	parameter int V_SYNC_LEN     = 8
) (
	input  wire logic                     pixel_clk,
	input  wire logic                     RESET_n,
	input  wire logic                     flip_i,
	output sf_video_pkg::beam_t           beam_o,
	output sf_video_pkg::video_ctl_t      video_o
);

	localparam logic [8:0] H_LAST = 9'(H_TOTAL - 1);
	localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);

	logic [8:0] h_cnt;
	logic [8:0] v_cnt;   // 264 lines need the ninth bit
	logic [8:0] h_nxt;
	logic [8:0] v_nxt;
	logic       h_wrap;
	sf_video_pkg::video_ctl_t ctl_nxt;

	//==========================================================================
	// counters
	//==========================================================================

	assign h_wrap = (h_cnt == H_LAST);
	assign h_nxt  = h_wrap ? 9'd0 : h_cnt + 9'd1;

	// vertical steps once per line
	always_comb begin
		v_nxt = v_cnt;
		if (h_wrap) begin
			v_nxt = (v_cnt == V_LAST) ? 9'd0 : v_cnt + 9'd1;
		end
	end

	// sync and blank decode on the next count so they line up with beam_o
	always_comb begin
		ctl_nxt.hblank = (h_nxt < H_ACTIVE_START) || (h_nxt >= H_ACTIVE_END);
		ctl_nxt.vblank = (v_nxt < V_ACTIVE_START) || (v_nxt >= V_ACTIVE_END);
		ctl_nxt.hsync  = (h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_START + H_SYNC_LEN);
		ctl_nxt.vsync  = (v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_START + V_SYNC_LEN);
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_cnt   <= '0;
			v_cnt   <= '0;
			beam_o  <= '0;
			video_o <= '{hsync: 1'b0, vsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
		end else begin
			h_cnt   <= h_nxt;
			v_cnt   <= v_nxt;
			video_o <= ctl_nxt;
			// screen flip mirrors both axes
			beam_o.h_pix <= flip_i ? ~h_nxt : h_nxt;
			beam_o.v_pix <= flip_i ? ~v_nxt[7:0] : v_nxt[7:0];
		end
	end

	// count must never reach the line length, even after a parameter change
	a_h_bound: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		int'(h_cnt) < H_TOTAL)
		else $error("horizontal count %0d outside line of %0d", h_cnt, H_TOTAL);

endmodule

`default_nettype wire

// ==== layer_mixer.sv ====
`default_nettype none

module layer_mixer (
	input  wire logic                       pixel_clk,
	input  wire logic                       RESET_n,
	input  wire sf_video_pkg::layer_px_t    layer_px_i,
	input  wire sf_video_pkg::video_ctl_t   video_i,
	input  wire logic                       pal_we_i,
	input  wire logic [7:0]                 pal_idx_i,
	input  wire sf_video_pkg::rgb_t         pal_dat_i,
	output sf_video_pkg::rgb_t              rgb_o,
	output sf_video_pkg::video_ctl_t        video_o
);

	sf_video_pkg::layer_sel_e layer_sel;
	logic [7:0] win_idx;

	logic [7:0] idx_s1;
	sf_video_pkg::video_ctl_t video_s1;
	logic       blank_s1;

	sf_video_pkg::rgb_t pal_mem [256];

	//==========================================================================
	// stage 1 priority
	//==========================================================================

	// fg beats sprites beats bg, transparency is a zero low field
	always_comb begin
		if (|layer_px_i.fg[1:0]) begin
			layer_sel = sf_video_pkg::SEL_FG;
		end else if (|layer_px_i.sp[3:0]) begin
			layer_sel = sf_video_pkg::SEL_SP;
		end else begin
			layer_sel = sf_video_pkg::SEL_BG;
		end
	end

	always_comb begin
		case (layer_sel)
			sf_video_pkg::SEL_FG: win_idx = layer_px_i.fg;
			sf_video_pkg::SEL_SP: win_idx = layer_px_i.sp;
			default:              win_idx = layer_px_i.bg;
		endcase
	end

	always_ff @(posedge pixel_clk) begin
		idx_s1 <= win_idx;
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			video_s1 <= '{hsync: 1'b0, vsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
		end else begin
			video_s1 <= video_i;   // keep sync with the colour
		end
	end

	//==========================================================================
	// stage 2 palette
	//==========================================================================

	always_ff @(posedge pixel_clk) begin
		if (pal_we_i) begin
			pal_mem[pal_idx_i] <= pal_dat_i;
		end
	end

	assign blank_s1 = video_s1.hblank | video_s1.vblank;

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rgb_o   <= '0;
			video_o <= '{hsync: 1'b0, vsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
		end else begin
			rgb_o   <= blank_s1 ? '0 : pal_mem[idx_s1];
			video_o <= video_s1;
		end
	end

	a_blank_black: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(video_o.hblank || video_o.vblank) |-> (rgb_o == '0))
		else $error("colour output during blanking");

endmodule

`default_nettype wire

// ==== scroll_adder.sv ====
`default_nettype none

module scroll_adder (
	input  wire logic                    pixel_clk,
	input  wire logic                    RESET_n,
	input  wire sf_video_pkg::beam_t     beam_i,
	input  wire sf_video_pkg::scroll_t   scroll_i,
	output sf_video_pkg::beam_t          bg_coord_o
);

	logic [8:0] h_sum;
	logic [7:0] v_sum;

	// 9 bit and 8 bit adders side by side, carry out of each is dropped
	// so the background wraps around its tilemap
	always_comb begin
		h_sum = beam_i.h_pix + scroll_i.h_scroll;
		v_sum = beam_i.v_pix + scroll_i.v_scroll;
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bg_coord_o <= '0;
		end else begin
			bg_coord_o.h_pix <= h_sum;   // one cycle behind beam
			bg_coord_o.v_pix <= v_sum;
		end
	end

endmodule

`default_nettype wire

// ==== sf_video_pkg.sv ====
`default_nettype none

package sf_video_pkg;

	//==========================================================================
	// video path types
	//==========================================================================

	// beam position, 9 bit horizontal and 8 bit vertical
	typedef struct packed {
		logic [8:0] h_pix;
		logic [7:0] v_pix;
	} beam_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_ctl_t;

	// one colour index per layer
	typedef struct packed {
		logic [7:0] fg;   // foreground
		logic [7:0] sp;   // sprites
		logic [7:0] bg;   // background
	} layer_px_t;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	typedef struct packed {
		logic [8:0] h_scroll;
		logic [7:0] v_scroll;
	} scroll_t;

	//==========================================================================
	// wishbone classic bus
	//==========================================================================

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [8:0]  adr;   // word address
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// register map
	typedef enum logic [8:0] {
		REG_HSCROLL_LO = 9'd0,
		REG_HSCROLL_HI = 9'd1,
		REG_VSCROLL    = 9'd2,
		REG_CONTROL    = 9'd3
	} reg_addr_e;

	localparam logic [8:0] PALETTE_BASE = 9'd256;   // 256 entries from here
	localparam int CTRL_FLIP_BIT = 0;

	typedef enum logic [1:0] {
		SEL_FG,
		SEL_SP,
		SEL_BG
	} layer_sel_e;

endpackage

`default_nettype wire

// ==== slapfight_video.sv ====
`default_nettype none

module slapfight_video #(
	parameter int H_TOTAL        = 384,
	parameter int H_ACTIVE_START = 14,
	parameter int H_ACTIVE_END   = 283,
	parameter int H_SYNC_START   = 300,
	parameter int H_SYNC_LEN     = 32,
	parameter int V_TOTAL        = 264,
	parameter int V_ACTIVE_START = 16,
	parameter int V_ACTIVE_END   = 240,
	parameter int V_SYNC_START   = 248,
	parameter int V_SYNC_LEN     = 8
) (
	input  wire logic                       pixel_clk,
	input  wire logic                       RESET_n,
	input  wire sf_video_pkg::wb_req_t      wb_req_i,
	output sf_video_pkg::wb_rsp_t           wb_rsp_o,
	input  wire sf_video_pkg::layer_px_t    layer_px_i,
	output sf_video_pkg::beam_t             beam_o,
	output sf_video_pkg::beam_t             bg_coord_o,
	output sf_video_pkg::rgb_t              rgb_o,
	output sf_video_pkg::video_ctl_t        video_o
);

	wire sf_video_pkg::scroll_t    scroll;
	wire sf_video_pkg::video_ctl_t beam_ctl;   // sync/blank ahead of the mixer
	wire sf_video_pkg::rgb_t       pal_dat;
	wire logic                     flip;
	wire logic                     pal_we;
	wire logic [7:0]               pal_idx;

	beam_timing #(
		.H_TOTAL        (H_TOTAL),
		.H_ACTIVE_START (H_ACTIVE_START),
		.H_ACTIVE_END   (H_ACTIVE_END),
		.H_SYNC_START   (H_SYNC_START),
		.H_SYNC_LEN     (H_SYNC_LEN),
		.V_TOTAL        (V_TOTAL),
		.V_ACTIVE_START (V_ACTIVE_START),
		.V_ACTIVE_END   (V_ACTIVE_END),
		.V_SYNC_START   (V_SYNC_START),
		.V_SYNC_LEN     (V_SYNC_LEN)
	) u_timing (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip),
		.beam_o    (beam_o),
		.video_o   (beam_ctl)
	);

	video_regs u_regs (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.wb_req_i  (wb_req_i),
		.wb_rsp_o  (wb_rsp_o),
		.scroll_o  (scroll),
		.flip_o    (flip),
		.pal_we_o  (pal_we),
		.pal_idx_o (pal_idx),
		.pal_dat_o (pal_dat)
	);

	scroll_adder u_scroll (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.beam_i     (beam_o),
		.scroll_i   (scroll),
		.bg_coord_o (bg_coord_o)
	);

	layer_mixer u_mixer (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.layer_px_i (layer_px_i),
		.video_i    (beam_ctl),
		.pal_we_i   (pal_we),
		.pal_idx_i  (pal_idx),
		.pal_dat_i  (pal_dat),
		.rgb_o      (rgb_o),
		.video_o    (video_o)
	);

endmodule

`default_nettype wire

// ==== sources.f ====
sf_video_pkg.sv
beam_timing.sv
video_regs.sv
scroll_adder.sv
layer_mixer.sv
slapfight_video.sv
tb_checks.sv
tb_slapfight_video.sv

// ==== tb_checks.sv ====
`default_nettype none

module tb_checks #(
	parameter int H_TOTAL        = 64,
	parameter int H_ACTIVE_START = 4,
	parameter int H_ACTIVE_END   = 52,
	parameter int H_SYNC_LEN     = 4,
	parameter int V_TOTAL        = 40,
	parameter int V_ACTIVE_START = 2,
	parameter int V_ACTIVE_END   = 34
) (
	input  wire logic                       pixel_clk,
	input  wire logic                       RESET_n,
	input  wire sf_video_pkg::wb_req_t      wb_req_i,
	input  wire sf_video_pkg::wb_rsp_t      wb_rsp_i,
	input  wire sf_video_pkg::layer_px_t    layer_px_i,
	input  wire sf_video_pkg::beam_t        beam_i,
	input  wire sf_video_pkg::beam_t        bg_coord_i,
	input  wire sf_video_pkg::rgb_t         rgb_i,
	input  wire sf_video_pkg::video_ctl_t   video_i,
	output logic                            err_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// pixel clocks per frame with vblank low
	localparam int V_ACTIVE_CYC = (V_ACTIVE_END - V_ACTIVE_START) * H_TOTAL;

	logic        pend;
	logic        rst_seen;
	logic [8:0]  h_ref;
	logic [8:0]  v_ref;
	logic        flip_q;
	logic [7:0]  ctrl_m;
	logic [255:0] pal_ok;
	logic [7:0]  idx_q;
	logic        exp_ok;
	logic        hs_d;
	logic        vs_d;
	logic        hb_d;
	logic        vb_d;
	logic        hs_seen;
	logic        vs_seen;
	logic        lo_seen;
	logic        vlo_seen;
	int          hs_per;
	int          hs_len;
	int          vs_per;
	int          lo_len;
	int          vlo_len;
	int          hit_fg;
	int          hit_sp;
	int          hit_bg;
	int          vs_checks;   // full frames measured
	sf_video_pkg::scroll_t    scr_m;
	sf_video_pkg::beam_t      exp_bg;
	sf_video_pkg::rgb_t       exp_rgb;
	sf_video_pkg::rgb_t       pal_m [256];
	sf_video_pkg::layer_sel_e sel_q1;
	sf_video_pkg::layer_sel_e sel_q2;

	initial err_o = 1'b0;

	task automatic flag(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
		err_o = 1'b1;
	endtask

	task automatic flag_msg(input string what);
		$display("error: %s", what);
		err_o = 1'b1;
	endtask

	// fg opaque on low two bits, sprites on low four, bg otherwise
	function automatic sf_video_pkg::layer_sel_e pick_layer(sf_video_pkg::layer_px_t px);
		if (|px.fg[1:0])
			return sf_video_pkg::SEL_FG;
		if (|px.sp[3:0])
			return sf_video_pkg::SEL_SP;
		return sf_video_pkg::SEL_BG;
	endfunction

	function automatic logic [7:0] layer_index(sf_video_pkg::layer_px_t px,
			sf_video_pkg::layer_sel_e sel);
		case (sel)
			sf_video_pkg::SEL_FG: return px.fg;
			sf_video_pkg::SEL_SP: return px.sp;
			default:              return px.bg;
		endcase
	endfunction

	function automatic logic [15:0] readback(logic [8:0] adr);
		if (adr >= sf_video_pkg::PALETTE_BASE)
			return 16'd0;   // palette reads as zero
		case (adr)
			sf_video_pkg::REG_HSCROLL_LO: return {8'd0, scr_m.h_scroll[7:0]};
			sf_video_pkg::REG_HSCROLL_HI: return {15'd0, scr_m.h_scroll[8]};
			sf_video_pkg::REG_VSCROLL:    return {8'd0, scr_m.v_scroll};
			sf_video_pkg::REG_CONTROL:    return {8'd0, ctrl_m};
			default:                      return 16'd0;
		endcase
	endfunction

	//==========================================================================
	// bus model and handshake
	//==========================================================================

	assign pend = wb_req_i.cyc & wb_req_i.stb;

	always @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			scr_m  <= '0;
			ctrl_m <= '0;
			pal_ok <= '0;
		end else begin
			// registers take the write as the slave samples it
			if (pend && !wb_rsp_i.ack && wb_req_i.we) begin
				case (wb_req_i.adr)
					sf_video_pkg::REG_HSCROLL_LO: scr_m.h_scroll[7:0] <= wb_req_i.dat[7:0];
					sf_video_pkg::REG_HSCROLL_HI: scr_m.h_scroll[8] <= wb_req_i.dat[0];
					sf_video_pkg::REG_VSCROLL:    scr_m.v_scroll <= wb_req_i.dat[7:0];
					sf_video_pkg::REG_CONTROL:    ctrl_m <= wb_req_i.dat[7:0];
					default: ;
				endcase
			end
			if (wb_rsp_i.ack && wb_req_i.we && wb_req_i.adr >= sf_video_pkg::PALETTE_BASE) begin
				pal_m[wb_req_i.adr[7:0]]  <= sf_video_pkg::rgb_t'(wb_req_i.dat[11:0]);
				pal_ok[wb_req_i.adr[7:0]] <= 1'b1;   // ram entry lands with the ack
			end
			if (wb_rsp_i.ack && !wb_req_i.we) begin
				assert (wb_rsp_i.dat == readback(wb_req_i.adr))
					else flag("bus read", readback(wb_req_i.adr), wb_rsp_i.dat);
			end
		end
	end

	a_ack_next: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		(pend && !wb_rsp_i.ack) |=> wb_rsp_i.ack)
		else flag_msg("bus request was not acknowledged on the next cycle");

	a_ack_once: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
		else flag_msg("ack stayed high for more than one cycle");

	always @(posedge pixel_clk) begin
		rst_seen <= RESET_n;
		if (!RESET_n || !rst_seen) begin
			assert (!video_i.hsync && !video_i.vsync && !wb_rsp_i.ack && rgb_i == '0)
				else flag_msg("outputs not idle during or right after reset");
		end
	end

	//==========================================================================
	// beam position, flip and scroll
	//==========================================================================

	always @(posedge pixel_clk or negedge RESET_n) begin
		logic [8:0] exp_h;
		logic [7:0] exp_v;
		if (!RESET_n) begin
			h_ref  <= '0;
			v_ref  <= '0;
			flip_q <= 1'b0;
			exp_bg <= '0;
		end else begin
			exp_h = flip_q ? ~h_ref : h_ref;
			exp_v = flip_q ? ~v_ref[7:0] : v_ref[7:0];
			assert (beam_i.h_pix == exp_h)
				else flag(flip_q ? "flip h_pix" : "beam h_pix", exp_h, beam_i.h_pix);
			assert (beam_i.v_pix == exp_v)
				else flag(flip_q ? "flip v_pix" : "beam v_pix", exp_v, beam_i.v_pix);
			assert (bg_coord_i == exp_bg) else flag("scroll", exp_bg, bg_coord_i);
			flip_q <= ctrl_m[sf_video_pkg::CTRL_FLIP_BIT];
			exp_bg.h_pix <= beam_i.h_pix + scr_m.h_scroll;   // wraps at 512
			exp_bg.v_pix <= beam_i.v_pix + scr_m.v_scroll;
			h_ref <= (h_ref == 9'(H_TOTAL - 1)) ? 9'd0 : h_ref + 9'd1;
			if (h_ref == 9'(H_TOTAL - 1))
				v_ref <= (v_ref == 9'(V_TOTAL - 1)) ? 9'd0 : v_ref + 9'd1;
		end
	end

	//==========================================================================
	// sync and blank lengths
	//==========================================================================

	always @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hs_d      <= 1'b0;
			vs_d      <= 1'b0;
			hb_d      <= 1'b0;
			vb_d      <= 1'b0;
			hs_seen   <= 1'b0;
			vs_seen   <= 1'b0;
			lo_seen   <= 1'b0;
			vlo_seen  <= 1'b0;
			vs_checks <= 0;
		end else begin
			hs_d <= video_i.hsync;
			vs_d <= video_i.vsync;
			hb_d <= video_i.hblank;
			vb_d <= video_i.vblank;
			if (video_i.hsync && !hs_d) begin
				if (hs_seen)
					assert (hs_per == H_TOTAL) else flag("hsync period", H_TOTAL, hs_per);
				hs_seen <= 1'b1;
				hs_per  <= 1;
				hs_len  <= 1;
			end else begin
				hs_per <= hs_per + 1;
				if (video_i.hsync)
					hs_len <= hs_len + 1;
			end
			if (!video_i.hsync && hs_d && hs_seen)
				assert (hs_len == H_SYNC_LEN) else flag("hsync length", H_SYNC_LEN, hs_len);
			if (video_i.vsync && !vs_d) begin
				if (vs_seen) begin
					assert (vs_per == H_TOTAL * V_TOTAL)
						else flag("vsync period", H_TOTAL * V_TOTAL, vs_per);
					vs_checks <= vs_checks + 1;
				end
				vs_seen <= 1'b1;
				vs_per  <= 1;
			end else begin
				vs_per <= vs_per + 1;
			end
			// active part of the line, first partial run skipped
			if (!video_i.hblank && hb_d) begin
				lo_seen <= 1'b1;
				lo_len  <= 1;
			end else if (!video_i.hblank) begin
				lo_len <= lo_len + 1;
			end
			if (video_i.hblank && !hb_d && lo_seen)
				assert (lo_len == H_ACTIVE_END - H_ACTIVE_START)
					else flag("active width", H_ACTIVE_END - H_ACTIVE_START, lo_len);
			// active part of the frame, same scheme in pixel clocks
			if (!video_i.vblank && vb_d) begin
				vlo_seen <= 1'b1;
				vlo_len  <= 1;
			end else if (!video_i.vblank) begin
				vlo_len <= vlo_len + 1;
			end
			if (video_i.vblank && !vb_d && vlo_seen)
				assert (vlo_len == V_ACTIVE_CYC)
					else flag("active height", V_ACTIVE_CYC, vlo_len);
		end
	end

	//==========================================================================
	// layer priority and palette
	//==========================================================================

	always @(posedge pixel_clk or negedge RESET_n) begin
		sf_video_pkg::layer_sel_e sel_now;
		if (!RESET_n) begin
			exp_ok <= 1'b0;
			hit_fg <= 0;
			hit_sp <= 0;
			hit_bg <= 0;
		end else begin
			sel_now = pick_layer(layer_px_i);
			sel_q1  <= sel_now;
			idx_q   <= layer_index(layer_px_i, sel_now);
			sel_q2  <= sel_q1;
			exp_rgb <= pal_m[idx_q];
			exp_ok  <= pal_ok[idx_q];   // entries never written are not compared
			if (video_i.hblank || video_i.vblank) begin
				assert (rgb_i == '0) else flag("blanked colour", 0, rgb_i);
			end else if (exp_ok) begin
				// only compared pixels count towards priority coverage
				case (sel_q2)
					sf_video_pkg::SEL_FG: hit_fg <= hit_fg + 1;
					sf_video_pkg::SEL_SP: hit_sp <= hit_sp + 1;
					default:              hit_bg <= hit_bg + 1;
				endcase
				assert (rgb_i == exp_rgb)
					else flag($sformatf("mixing %s", sel_q2.name()), exp_rgb, rgb_i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_slapfight_video.sv ====
`default_nettype none

module tb_slapfight_video;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_TOTAL        = 64;
	localparam int H_ACTIVE_START = 4;
	localparam int H_ACTIVE_END   = 52;
	localparam int H_SYNC_START   = 54;
	localparam int H_SYNC_LEN     = 4;
	localparam int V_TOTAL        = 40;
	localparam int V_ACTIVE_START = 2;
	localparam int V_ACTIVE_END   = 34;
	localparam int V_SYNC_START   = 36;
	localparam int V_SYNC_LEN     = 2;

	localparam int RESET_CYCLES = 8;
	localparam int PIX_RUN      = 1800;   // three runs give two vsync rises
	// three cycles per bus transfer, doubled for margin
	localparam int MAX_CYCLES = 2 * (RESET_CYCLES + 3 * (256 + 40) + 3 * PIX_RUN);

	logic pixel_clk;
	logic RESET_n;
	logic check_err;
	logic [31:0] lfsr;
	int   cycle_cnt;
	sf_video_pkg::wb_req_t    wb_req;
	sf_video_pkg::wb_rsp_t    wb_rsp;
	sf_video_pkg::layer_px_t  layer_px;
	sf_video_pkg::beam_t      beam;
	sf_video_pkg::beam_t      bg_coord;
	sf_video_pkg::rgb_t       rgb;
	sf_video_pkg::video_ctl_t video;

	slapfight_video #(
		.H_TOTAL (H_TOTAL), .H_ACTIVE_START (H_ACTIVE_START), .H_ACTIVE_END (H_ACTIVE_END),
		.H_SYNC_START (H_SYNC_START), .H_SYNC_LEN (H_SYNC_LEN),
		.V_TOTAL (V_TOTAL), .V_ACTIVE_START (V_ACTIVE_START), .V_ACTIVE_END (V_ACTIVE_END),
		.V_SYNC_START (V_SYNC_START), .V_SYNC_LEN (V_SYNC_LEN)
	) u_dut (
		.pixel_clk (pixel_clk), .RESET_n (RESET_n),
		.wb_req_i (wb_req), .wb_rsp_o (wb_rsp), .layer_px_i (layer_px),
		.beam_o (beam), .bg_coord_o (bg_coord), .rgb_o (rgb), .video_o (video)
	);

	tb_checks #(
		.H_TOTAL (H_TOTAL), .H_ACTIVE_START (H_ACTIVE_START), .H_ACTIVE_END (H_ACTIVE_END),
		.H_SYNC_LEN (H_SYNC_LEN), .V_TOTAL (V_TOTAL),
		.V_ACTIVE_START (V_ACTIVE_START), .V_ACTIVE_END (V_ACTIVE_END)
	) u_checks (
		.pixel_clk (pixel_clk), .RESET_n (RESET_n),
		.wb_req_i (wb_req), .wb_rsp_i (wb_rsp), .layer_px_i (layer_px),
		.beam_i (beam), .bg_coord_i (bg_coord), .rgb_i (rgb), .video_i (video),
		.err_o (check_err)
	);

	always #2 pixel_clk = ~pixel_clk;

	task automatic end_fail(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge check_err) begin
		end_fail("stopping at the first failed check");
	end

	always @(posedge pixel_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			end_fail($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
	end

	//==========================================================================
	// random source and bus master
	//==========================================================================

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);   // taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// classic cycle, request held until ack is seen
	task automatic bus_cycle(input logic we, input logic [8:0] adr, input logic [15:0] dat);
		@(posedge pixel_clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do begin
			@(posedge pixel_clk);
		end while (!wb_rsp.ack);
		wb_req <= '0;
	endtask

	task automatic write_scroll();
		logic [31:0] r;
		take_bits(17, r);
		bus_cycle(1'b1, sf_video_pkg::REG_HSCROLL_LO, {8'd0, r[7:0]});
		bus_cycle(1'b1, sf_video_pkg::REG_HSCROLL_HI, {15'd0, r[8]});
		bus_cycle(1'b1, sf_video_pkg::REG_VSCROLL, {8'd0, r[16:9]});
		bus_cycle(1'b0, sf_video_pkg::REG_HSCROLL_LO, 16'd0);
		bus_cycle(1'b0, sf_video_pkg::REG_HSCROLL_HI, 16'd0);
		bus_cycle(1'b0, sf_video_pkg::REG_VSCROLL, 16'd0);
	endtask

	task automatic set_flip(input logic on);
		bus_cycle(1'b1, sf_video_pkg::REG_CONTROL, {15'd0, on});
		bus_cycle(1'b0, sf_video_pkg::REG_CONTROL, 16'd0);
	endtask

	task automatic fill_palette();
		logic [31:0] r;
		for (int i = 0; i < 256; i++) begin
			take_bits(12, r);
			bus_cycle(1'b1, sf_video_pkg::PALETTE_BASE + 9'(i), {4'd0, r[11:0]});
		end
	endtask

	task automatic run_pixels(input int n);
		logic [31:0] r;
		repeat (n) begin
			@(posedge pixel_clk);
			take_bits(24, r);
			layer_px <= r[23:0];
		end
	endtask

	initial begin
		pixel_clk = 1'b0;
		RESET_n   = 1'b0;
		wb_req    = '0;
		layer_px  = '0;
		lfsr      = 32'h631e2798;
		cycle_cnt = 0;
		repeat (RESET_CYCLES) @(posedge pixel_clk);
		RESET_n <= 1'b1;

		set_flip(1'b0);
		write_scroll();
		bus_cycle(1'b0, sf_video_pkg::PALETTE_BASE + 9'd17, 16'd0);
		fill_palette();
		run_pixels(PIX_RUN);
		write_scroll();
		set_flip(1'b1);
		run_pixels(PIX_RUN);
		write_scroll();
		set_flip(1'b0);
		run_pixels(PIX_RUN);
		repeat (4) @(posedge pixel_clk);
		@(negedge pixel_clk);   // let the checks of the last edge settle

		if (u_checks.hit_fg == 0 || u_checks.hit_sp == 0 || u_checks.hit_bg == 0) begin
			end_fail("a layer priority case was never reached");
		end else if (u_checks.vs_checks == 0) begin
			end_fail("no full frame was measured");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== video_regs.sv ====
`default_nettype none

module video_regs (
	input  wire logic                    pixel_clk,
	input  wire logic                    RESET_n,
	input  wire sf_video_pkg::wb_req_t   wb_req_i,
	output sf_video_pkg::wb_rsp_t        wb_rsp_o,
	output sf_video_pkg::scroll_t        scroll_o,
	output logic                         flip_o,
	output logic                         pal_we_o,
	output logic [7:0]                   pal_idx_o,
	output sf_video_pkg::rgb_t           pal_dat_o
);

	logic        req_pend;
	logic        accept;    // first cycle of a pending request
	logic        pal_hit;
	logic [8:0]  pal_off;
	logic [15:0] rd_mux;
	sf_video_pkg::reg_addr_e reg_sel;

	logic        ack_q;
	logic [15:0] rd_dat_q;
	logic [8:0]  h_scroll_q;
	logic [7:0]  v_scroll_q;
	logic [7:0]  ctrl_q;

	//==========================================================================
	// address decode
	//==========================================================================

	assign req_pend = wb_req_i.cyc & wb_req_i.stb;
	assign accept   = req_pend & ~ack_q;   // master still holds it during ack
	assign pal_hit  = (wb_req_i.adr >= sf_video_pkg::PALETTE_BASE);
	assign pal_off  = wb_req_i.adr - sf_video_pkg::PALETTE_BASE;
	assign reg_sel  = sf_video_pkg::reg_addr_e'(wb_req_i.adr);

	// readback, palette is write only
	always_comb begin
		rd_mux = '0;
		if (!pal_hit) begin
			case (reg_sel)
				sf_video_pkg::REG_HSCROLL_LO: rd_mux = {8'd0, h_scroll_q[7:0]};
				sf_video_pkg::REG_HSCROLL_HI: rd_mux = {15'd0, h_scroll_q[8]};
				sf_video_pkg::REG_VSCROLL:    rd_mux = {8'd0, v_scroll_q};
				sf_video_pkg::REG_CONTROL:    rd_mux = {8'd0, ctrl_q};
				default:                      rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			ack_q      <= 1'b0;
			pal_we_o   <= 1'b0;
			h_scroll_q <= '0;
			v_scroll_q <= '0;
			ctrl_q     <= '0;
		end else begin
			ack_q    <= accept;
			pal_we_o <= accept & wb_req_i.we & pal_hit;   // single cycle strobe
			if (accept && wb_req_i.we && !pal_hit) begin
				case (reg_sel)
					sf_video_pkg::REG_HSCROLL_LO: h_scroll_q[7:0] <= wb_req_i.dat[7:0];
					sf_video_pkg::REG_HSCROLL_HI: h_scroll_q[8]   <= wb_req_i.dat[0];
					sf_video_pkg::REG_VSCROLL:    v_scroll_q      <= wb_req_i.dat[7:0];
					sf_video_pkg::REG_CONTROL:    ctrl_q          <= wb_req_i.dat[7:0];
					default: ;
				endcase
			end
		end
	end

	// read data and palette payload
	always_ff @(posedge pixel_clk) begin
		if (accept) begin
			rd_dat_q <= rd_mux;
		end
		if (accept && wb_req_i.we && pal_hit) begin
			pal_idx_o <= pal_off[7:0];
			pal_dat_o <= sf_video_pkg::rgb_t'(wb_req_i.dat[11:0]);
		end
	end

	assign wb_rsp_o = '{ack: ack_q, dat: rd_dat_q};
	assign scroll_o = '{h_scroll: h_scroll_q, v_scroll: v_scroll_q};
	assign flip_o   = ctrl_q[sf_video_pkg::CTRL_FLIP_BIT];

	a_ack_single: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		ack_q |=> !ack_q)
		else $error("ack held for more than one cycle");

	a_ack_req: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb))
		else $error("ack without a pending request");

endmodule

`default_nettype wire
